// File: core_consts.svh
// ========================================
// widths and fixed values for the core
// include before any port or type that needs a width
// ========================================
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path and address width
`define XLEN        32
`define INSTR_W     32
`define REG_ADDR_W  5

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR   32'h0000_0013

`endif

// File: core_pkg.sv
// ========================================
// shared types of the rv32i pipeline
// opcodes, alu and hold codes, stage structs
// ========================================
`include "core_consts.svh"

package core_pkg;

	typedef enum logic [6:0] {
		OP_NONE   = 7'b0000000,
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_STORE  = 7'b0100011,
		OP_REG    = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B  // lui
	} alu_op_e;

	// higher code holds more stages
	typedef enum logic [1:0] {
		HOLD_NONE = 2'd0,
		HOLD_IF   = 2'd1,
		HOLD_ALL  = 2'd2
	} hold_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JAL
	} br_e;

	typedef struct packed {
		logic [`INSTR_W-1:0] instr;
		logic [`XLEN-1:0]    pc;
	} fetch_t;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rd;
		logic                   reg_wr_en;
		alu_op_e                alu_op;
		logic                   use_imm;  // operand b from imm
		logic [`XLEN-1:0]       imm;
		logic                   mem_rd;
		logic                   mem_wr;
		br_e                    br;
	} dec_t;

endpackage

// File: pc_gen.sv
// ========================================
// program counter of the fetch side
// steps by 4 unless held, jumps on redirect
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module pc_gen (
	input  logic             clk,
	input  logic             arst_n_i,
	input  core_pkg::hold_e  hold_i,
	input  logic             jmp_en_i,
	input  logic [`XLEN-1:0] jmp_to_i,
	output logic [`XLEN-1:0] pc_o
);

	import core_pkg::*;

	logic [`XLEN-1:0] pc_next;

	assign pc_next = pc_o + 4;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o <= `RESET_PC;
		end else if (jmp_en_i) begin
			pc_o <= jmp_to_i;  // even under a fetch hold
		end else if (hold_i == HOLD_NONE) begin
			pc_o <= pc_next;
		end
	end

endmodule

// File: if_stage.sv
// ========================================
// fetch register between pc and decode
// a flush or an executed held slot shows a nop
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module if_stage (
	input  logic                clk,
	input  logic                arst_n_i,
	input  core_pkg::hold_e     hold_i,
	input  logic                flush_i,
	input  logic [`INSTR_W-1:0] instr_i,
	input  logic [`XLEN-1:0]    pc_i,
	output core_pkg::fetch_t    fetch_o,
	output logic                instr_rd_en_o
);

	import core_pkg::*;

	fetch_t fetch_q;
	logic   spent_q;  // held slot already went through execute

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			fetch_q.instr <= `NOP_INSTR;
			fetch_q.pc    <= `RESET_PC;
			spent_q       <= 1'b0;
		end else if (flush_i) begin
			fetch_q.instr <= `NOP_INSTR;  // younger slot after a taken jump
			fetch_q.pc    <= pc_i;
			spent_q       <= 1'b0;
		end else begin
			case (hold_i)
				HOLD_NONE: begin
					fetch_q.instr <= instr_i;
					fetch_q.pc    <= pc_i;
					spent_q       <= 1'b0;
				end
				HOLD_IF: begin
					spent_q <= 1'b1;
				end
				default: begin
					spent_q <= spent_q;  // replay keeps the slot as is
				end
			endcase
		end
	end

	always_comb begin
		fetch_o = fetch_q;
		if (spent_q) begin
			fetch_o.instr = `NOP_INSTR;
		end
	end

	assign instr_rd_en_o = (hold_i == HOLD_NONE);

endmodule

// File: id_stage.sv
// ========================================
// instruction decoder, purely combinational
// unsupported encodings come out as a bubble
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module id_stage (
	input  core_pkg::fetch_t fetch_i,
	output core_pkg::dec_t   dec_o
);

	import core_pkg::*;

	logic [`INSTR_W-1:0] instr;
	opcode_e             opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic                f3_ok;
	logic [`XLEN-1:0]    imm_i;
	logic [`XLEN-1:0]    imm_s;
	logic [`XLEN-1:0]    imm_b;
	logic [`XLEN-1:0]    imm_u;
	logic [`XLEN-1:0]    imm_j;

	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
		alu_op_e op;
		case (f3)
			3'b000:  op = sub ? ALU_SUB : ALU_ADD;
			3'b010:  op = ALU_SLT;
			3'b100:  op = ALU_XOR;
			3'b110:  op = ALU_OR;
			3'b111:  op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	assign instr  = fetch_i.instr;
	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign f3_ok  = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};  // no shifts

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec_o        = '0;
		dec_o.rs1    = instr[19:15];
		dec_o.rs2    = instr[24:20];
		dec_o.rd     = instr[11:7];
		dec_o.alu_op = ALU_ADD;
		dec_o.br     = BR_NONE;
		case (opcode)
			OP_REG: begin
				dec_o.alu_op    = alu_decode(funct3, funct7[5]);
				dec_o.reg_wr_en = f3_ok && (funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && funct3 == 3'b000));
			end
			OP_IMM: begin
				dec_o.alu_op    = alu_decode(funct3, 1'b0);
				dec_o.use_imm   = 1'b1;
				dec_o.imm       = imm_i;
				dec_o.reg_wr_en = f3_ok;
			end
			OP_LUI: begin
				dec_o.alu_op    = ALU_PASS_B;
				dec_o.use_imm   = 1'b1;
				dec_o.imm       = imm_u;
				dec_o.reg_wr_en = 1'b1;
			end
			OP_LOAD: begin
				dec_o.use_imm   = 1'b1;
				dec_o.imm       = imm_i;
				dec_o.mem_rd    = (funct3 == 3'b010);  // lw only
				dec_o.reg_wr_en = (funct3 == 3'b010);
			end
			OP_STORE: begin
				dec_o.use_imm = 1'b1;
				dec_o.imm     = imm_s;
				dec_o.mem_wr  = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				dec_o.imm = imm_b;
				if (funct3 == 3'b000) begin
					dec_o.br = BR_EQ;
				end else if (funct3 == 3'b001) begin
					dec_o.br = BR_NE;
				end
			end
			OP_JAL: begin
				dec_o.imm       = imm_j;
				dec_o.br        = BR_JAL;
				dec_o.reg_wr_en = 1'b1;
			end
			default: begin
				dec_o.br = BR_NONE;  // unknown opcode
			end
		endcase
		if (dec_o.rd == '0) begin
			dec_o.reg_wr_en = 1'b0;
		end
	end

endmodule

// File: regs.sv
// ========================================
// 32 x 32-bit register file
// two async read ports, one write port, x0 reads 0
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module regs (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   wr_en_i,
	input  logic [`REG_ADDR_W-1:0] addr_wr_i,
	input  logic [`XLEN-1:0]       data_wr_i,
	input  logic [`REG_ADDR_W-1:0] addr_rd1_i,
	input  logic [`REG_ADDR_W-1:0] addr_rd2_i,
	output logic [`XLEN-1:0]       data_rd1_o,
	output logic [`XLEN-1:0]       data_rd2_o
);

	logic [`XLEN-1:0] mem [0:(1 << `REG_ADDR_W)-1];

	always_ff @(posedge clk) begin
		if (wr_en_i && addr_wr_i != '0) begin
			mem[addr_wr_i] <= data_wr_i;
		end
	end

	assign data_rd1_o = (addr_rd1_i == '0) ? '0 : mem[addr_rd1_i];
	assign data_rd2_o = (addr_rd2_i == '0) ? '0 : mem[addr_rd2_i];

	// decode drops rd == x0, so the enable never arrives for it
	a_no_x0_wr: assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_en_i |-> addr_wr_i != '0)
		else $error("register write aimed at x0");

endmodule

// File: ex_stage.sv
// ========================================
// execute stage: alu, branch resolve, memory strobes
// and the write-back value for the register file
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module ex_stage (
	input  core_pkg::hold_e        hold_i,
	input  core_pkg::dec_t         dec_i,
	input  logic [`XLEN-1:0]       pc_i,
	input  logic [`XLEN-1:0]       data_rs1_i,
	input  logic [`XLEN-1:0]       data_rs2_i,
	input  logic [`XLEN-1:0]       data_mem_i,
	output logic                   reg_wr_en_o,
	output logic [`REG_ADDR_W-1:0] addr_reg_wr_o,
	output logic [`XLEN-1:0]       data_reg_wr_o,
	output logic                   mem_rd_en_o,
	output logic                   mem_wr_en_o,
	output logic [`XLEN-1:0]       addr_mem_rd_o,
	output logic [`XLEN-1:0]       addr_mem_wr_o,
	output logic [`XLEN-1:0]       data_mem_wr_o,
	output logic                   jmp_en_o,
	output logic [`XLEN-1:0]       jmp_to_o
);

	import core_pkg::*;

	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_res;
	logic [`XLEN-1:0] link;

	assign op_b = dec_i.use_imm ? dec_i.imm : data_rs2_i;
	assign link = pc_i + 4;

	always_comb begin
		case (dec_i.alu_op)
			ALU_SUB:    alu_res = data_rs1_i - op_b;
			ALU_AND:    alu_res = data_rs1_i & op_b;
			ALU_OR:     alu_res = data_rs1_i | op_b;
			ALU_XOR:    alu_res = data_rs1_i ^ op_b;
			ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(data_rs1_i) < $signed(op_b)};
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = data_rs1_i + op_b;  // add, load/store address
		endcase
	end

	always_comb begin
		case (dec_i.br)
			BR_EQ:   jmp_en_o = (data_rs1_i == data_rs2_i);
			BR_NE:   jmp_en_o = (data_rs1_i != data_rs2_i);
			BR_JAL:  jmp_en_o = 1'b1;
			default: jmp_en_o = 1'b0;
		endcase
	end

	assign jmp_to_o = pc_i + dec_i.imm;

	assign mem_rd_en_o   = dec_i.mem_rd;
	assign mem_wr_en_o   = dec_i.mem_wr;
	assign addr_mem_rd_o = alu_res;
	assign addr_mem_wr_o = alu_res;
	assign data_mem_wr_o = data_rs2_i;

	// replayed under a memory stall, so write only once it clears
	assign reg_wr_en_o   = dec_i.reg_wr_en && (hold_i != HOLD_ALL);
	assign addr_reg_wr_o = dec_i.rd;

	always_comb begin
		if (dec_i.br == BR_JAL) begin
			data_reg_wr_o = link;
		end else if (dec_i.mem_rd) begin
			data_reg_wr_o = data_mem_i;
		end else begin
			data_reg_wr_o = alu_res;
		end
	end

	// decode never marks one instruction as both load and store
	always_comb begin
		assert (!(mem_rd_en_o && mem_wr_en_o))
			else $error("load and store strobe in the same cycle");
	end

endmodule

// File: ctrl.sv
// ========================================
// pipeline control with the hold code from the stall inputs
// and the flush of the fetch slot on a taken jump
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module ctrl (
	input  logic             stall_if_i,
	input  logic             stall_mem_i,
	input  logic             jmp_en_i,
	input  logic [`XLEN-1:0] jmp_to_i,
	output core_pkg::hold_e  hold_o,
	output logic             flush_o,
	output logic             jmp_en_o,
	output logic [`XLEN-1:0] jmp_to_o
);

	import core_pkg::*;

	always_comb begin
		if (stall_mem_i) begin
			hold_o = HOLD_ALL;  // memory side wins
		end else if (stall_if_i) begin
			hold_o = HOLD_IF;
		end else begin
			hold_o = HOLD_NONE;
		end
	end

	// the jump repeats while everything is held and is taken afterwards
	assign jmp_en_o = jmp_en_i && (hold_o < HOLD_ALL);
	assign flush_o  = jmp_en_o;
	assign jmp_to_o = jmp_to_i;

endmodule

// File: core.sv
// ========================================
// rv32i core top: pc, fetch, decode/execute, regs
// instruction and data memories sit outside
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module core (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                stall_if_i,
	input  logic                stall_mem_i,
	input  logic [`INSTR_W-1:0] instr_i,
	input  logic [`XLEN-1:0]    data_mem_i,
	output logic [`XLEN-1:0]    pc_o,
	output logic                instr_rd_en_o,
	output logic                mem_rd_en_o,
	output logic                mem_wr_en_o,
	output logic [`XLEN-1:0]    addr_mem_rd_o,
	output logic [`XLEN-1:0]    addr_mem_wr_o,
	output logic [`XLEN-1:0]    data_mem_wr_o
);

	import core_pkg::*;

	hold_e                  hold;
	fetch_t                 fetch;
	dec_t                   dec;
	logic                   flush;
	logic                   jmp_en_ex;
	logic                   jmp_en;
	logic [`XLEN-1:0]       jmp_to_ex;
	logic [`XLEN-1:0]       jmp_to;
	logic [`XLEN-1:0]       rs1_data;
	logic [`XLEN-1:0]       rs2_data;
	logic                   wb_en;
	logic [`REG_ADDR_W-1:0] wb_addr;
	logic [`XLEN-1:0]       wb_data;

	pc_gen core_pc (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.hold_i   (hold),
		.jmp_en_i (jmp_en),
		.jmp_to_i (jmp_to),
		.pc_o     (pc_o)
	);

	if_stage core_if (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.hold_i        (hold),
		.flush_i       (flush),
		.instr_i       (instr_i),
		.pc_i          (pc_o),
		.fetch_o       (fetch),
		.instr_rd_en_o (instr_rd_en_o)
	);

	id_stage core_id (
		.fetch_i (fetch),
		.dec_o   (dec)
	);

	regs core_regs (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.wr_en_i    (wb_en),
		.addr_wr_i  (wb_addr),
		.data_wr_i  (wb_data),
		.addr_rd1_i (dec.rs1),
		.addr_rd2_i (dec.rs2),
		.data_rd1_o (rs1_data),
		.data_rd2_o (rs2_data)
	);

	ex_stage core_ex (
		.hold_i        (hold),
		.dec_i         (dec),
		.pc_i          (fetch.pc),
		.data_rs1_i    (rs1_data),
		.data_rs2_i    (rs2_data),
		.data_mem_i    (data_mem_i),
		.reg_wr_en_o   (wb_en),
		.addr_reg_wr_o (wb_addr),
		.data_reg_wr_o (wb_data),
		.mem_rd_en_o   (mem_rd_en_o),
		.mem_wr_en_o   (mem_wr_en_o),
		.addr_mem_rd_o (addr_mem_rd_o),
		.addr_mem_wr_o (addr_mem_wr_o),
		.data_mem_wr_o (data_mem_wr_o),
		.jmp_en_o      (jmp_en_ex),
		.jmp_to_o      (jmp_to_ex)
	);

	ctrl core_ctrl (
		.stall_if_i  (stall_if_i),
		.stall_mem_i (stall_mem_i),
		.jmp_en_i    (jmp_en_ex),
		.jmp_to_i    (jmp_to_ex),
		.hold_o      (hold),
		.flush_o     (flush),
		.jmp_en_o    (jmp_en),
		.jmp_to_o    (jmp_to)
	);

endmodule

// File: tb_core.sv
// ========================================
// testbench for the rv32i core
// models both memories, loads small programs
// and checks the stored words of each test
// ========================================
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core;

	logic                clk;
	logic                arst_n_i;
	logic                stall_if_i;
	logic                stall_mem_i;
	logic [`INSTR_W-1:0] instr_i;
	logic [`XLEN-1:0]    data_mem_i;
	logic [`XLEN-1:0]    pc_o;
	logic                instr_rd_en_o;
	logic                mem_rd_en_o;
	logic                mem_wr_en_o;
	logic [`XLEN-1:0]    addr_mem_rd_o;
	logic [`XLEN-1:0]    addr_mem_wr_o;
	logic [`XLEN-1:0]    data_mem_wr_o;

	logic [`INSTR_W-1:0] imem [0:255];
	logic [`XLEN-1:0]    dmem [0:255];
	int                  wcount [0:255];  // writes per data word
	logic [`XLEN-1:0]    wlog [$];
	logic [`XLEN-1:0]    rlog [$];
	bit                  done;
	bit                  if_stall_on;
	bit                  mem_stall_on;
	int                  pc_idx;
	int                  errors;
	int                  checks;
	int                  tests;
	int                  failed;
	logic [`XLEN-1:0]    ld_val [0:3];
	logic [11:0]         ld_addr [0:3];

	core DUT (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.stall_if_i    (stall_if_i),
		.stall_mem_i   (stall_mem_i),
		.instr_i       (instr_i),
		.data_mem_i    (data_mem_i),
		.pc_o          (pc_o),
		.instr_rd_en_o (instr_rd_en_o),
		.mem_rd_en_o   (mem_rd_en_o),
		.mem_wr_en_o   (mem_wr_en_o),
		.addr_mem_rd_o (addr_mem_rd_o),
		.addr_mem_wr_o (addr_mem_wr_o),
		.data_mem_wr_o (data_mem_wr_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign instr_i    = imem[pc_o[9:2]];
	assign data_mem_i = dmem[addr_mem_rd_o[9:2]];

	// a store held by a memory stall lands once the stall drops
	always @(posedge clk) begin
		if (arst_n_i && mem_wr_en_o && !stall_mem_i) begin
			dmem[addr_mem_wr_o[9:2]] <= data_mem_wr_o;
			wcount[addr_mem_wr_o[9:2]]++;
			wlog.push_back(addr_mem_wr_o);
			if (addr_mem_wr_o == 32'h3fc) begin
				done = 1'b1;  // end marker of every program
			end
		end
		if (arst_n_i && mem_rd_en_o && !stall_mem_i) begin
			rlog.push_back(addr_mem_rd_o);  // a load counts once it completes
		end
	end

	function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_word(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_word(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// funct3 of add, and, or, xor, slt in that order
	function automatic logic [2:0] f3_of(int k);
		case (k)
			1:       return 3'b111;
			2:       return 3'b110;
			3:       return 3'b100;
			4:       return 3'b010;
			default: return 3'b000;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] alu_ref(int k, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
		case (k)
			1:       return a & b;
			2:       return a | b;
			3:       return a ^ b;
			4:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	task automatic put(logic [31:0] instr);
		imem[pc_idx] = instr;
		pc_idx++;
	endtask

	task automatic load_const(logic [4:0] rd, logic [31:0] v);
		logic [31:0] up;
		up = v + 32'h800;  // addi sign-extends the low part
		put({up[31:12], rd, 7'b0110111});
		put(i_word(v[11:0], rd, 3'b000, rd, 7'b0010011));
	endtask

	task automatic end_program();
		put(s_word(12'h3fc, 5'd0, 5'd0));
		put(jal_word(21'd0, 5'd0));  // spin in place
	endtask

	task automatic check_word(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected address %h actual address %h", name, exp, act);
		end
	endtask

	// reset stays low while the next program goes in
	task automatic start_test();
		@(negedge clk);
		arst_n_i    = 1'b0;
		stall_if_i  = 1'b0;
		stall_mem_i = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i]   = `NOP_INSTR;
			dmem[i]   = {16'hc3c3, i[7:0], ~i[7:0]};
			wcount[i] = 0;
		end
		wlog.delete();
		rlog.delete();
		done         = 1'b0;
		pc_idx       = 0;
		if_stall_on  = 1'b0;
		mem_stall_on = 1'b0;
	endtask

	task automatic release_reset();
		repeat (5) @(negedge clk);
		arst_n_i = 1'b1;
	endtask

	task automatic run_to_done(string name);
		int  cyc;
		int  hold_left;
		bit  prev;
		cyc       = 0;
		hold_left = 0;
		prev      = 1'b0;
		while (!done && cyc < 2000) begin
			@(negedge clk);
			cyc++;
			// fetch reads only while nothing holds it
			check_word({name, " fetch enable"}, {31'd0, !(stall_if_i || stall_mem_i)},
				{31'd0, instr_rd_en_o});
			stall_if_i = if_stall_on ? ($urandom % 4 == 0) : 1'b0;
			if (hold_left > 0) begin
				stall_mem_i = 1'b1;
				hold_left--;
			end else if (mem_stall_on && !prev && (mem_rd_en_o || mem_wr_en_o)) begin
				stall_mem_i = 1'b1;
				hold_left   = 2 + $urandom % 3;
			end else begin
				stall_mem_i = 1'b0;
			end
			prev = stall_mem_i;
		end
		@(negedge clk);
		stall_if_i  = 1'b0;
		stall_mem_i = 1'b0;
		if (!done) begin
			errors++;
			$display("%s: timeout, the final store never came", name);
		end
	endtask

	task automatic finish_test(string name, int errs_before);
		tests++;
		if (errors > errs_before) begin
			failed++;
			$display("%s: %0d mismatches", name, errors - errs_before);
		end else begin
			$display("%s: pass", name);
		end
	endtask

	task automatic alu_test(string name, logic [31:0] a, logic [31:0] b, logic [11:0] imm,
		bit stall_if);
		int               errs;
		logic [`XLEN-1:0] si;
		logic [11:0]      addr;
		errs = errors;
		si   = {{20{imm[11]}}, imm};
		start_test();
		if_stall_on = stall_if;
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int k = 0; k < 5; k++) begin
			put(r_word(7'h00, 5'd2, 5'd1, f3_of(k), 5'd3));
			put(s_word(12'h100 + 12'(4 * k), 5'd3, 5'd0));
			put(i_word(imm, 5'd1, f3_of(k), 5'd3, 7'b0010011));
			put(s_word(12'h140 + 12'(4 * k), 5'd3, 5'd0));
		end
		put(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));  // sub
		put(s_word(12'h180, 5'd3, 5'd0));
		end_program();
		release_reset();
		run_to_done(name);
		for (int k = 0; k < 5; k++) begin
			addr = 12'h100 + 12'(4 * k);
			check_word({name, " reg op"}, alu_ref(k, a, b), dmem[addr[9:2]]);
			check_word({name, " reg op stores"}, 1, wcount[addr[9:2]]);
			addr = 12'h140 + 12'(4 * k);
			check_word({name, " imm op"}, alu_ref(k, a, si), dmem[addr[9:2]]);
			check_word({name, " imm op stores"}, 1, wcount[addr[9:2]]);
		end
		check_word({name, " sub"}, a - b, dmem[8'h60]);
		check_word({name, " sub stores"}, 1, wcount[8'h60]);
		finish_test(name, errs);
	endtask

	task automatic mem_test(string name, bit mem_stall);
		int               errs;
		logic [`XLEN-1:0] sum;
		errs = errors;
		start_test();
		mem_stall_on = mem_stall;
		for (int i = 0; i < 4; i++) begin
			load_const(5'd1, ld_val[i]);
			put(s_word(ld_addr[i], 5'd1, 5'd0));
		end
		put(i_word(ld_addr[0], 5'd0, 3'b010, 5'd7, 7'b0000011));
		for (int i = 1; i < 4; i++) begin
			put(i_word(ld_addr[i], 5'd0, 3'b010, 5'd5, 7'b0000011));
			put(r_word(7'h00, 5'd5, 5'd7, 3'b000, 5'd7));
		end
		put(s_word(12'h104, 5'd7, 5'd0));
		end_program();
		release_reset();
		run_to_done(name);
		sum = ld_val[0] + ld_val[1] + ld_val[2] + ld_val[3];
		check_word({name, " sum"}, sum, dmem[8'h41]);
		check_word({name, " store count"}, 6, wlog.size());
		for (int i = 0; i < 4 && i < wlog.size(); i++) begin
			check_addr({name, " store"}, {20'd0, ld_addr[i]}, wlog[i]);
		end
		if (wlog.size() > 4) begin
			check_addr({name, " sum store"}, 32'h104, wlog[4]);
		end
		check_word({name, " load count"}, 4, rlog.size());
		for (int i = 0; i < 4 && i < rlog.size(); i++) begin
			check_addr({name, " load"}, {20'd0, ld_addr[i]}, rlog[i]);
		end
		finish_test(name, errs);
	endtask

	task automatic branch_test(string name);
		int               errs;
		logic [`XLEN-1:0] jal_pc;
		errs = errors;
		start_test();
		load_const(5'd1, 32'd5);
		load_const(5'd2, 32'd5);
		load_const(5'd3, 32'd7);
		put(b_word(13'd8, 5'd2, 5'd1, 3'b000));  // beq taken
		put(s_word(12'h180, 5'd3, 5'd0));
		put(b_word(13'd8, 5'd2, 5'd1, 3'b001));  // bne not taken
		put(s_word(12'h184, 5'd3, 5'd0));
		put(b_word(13'd8, 5'd3, 5'd1, 3'b001));  // bne taken
		put(s_word(12'h188, 5'd3, 5'd0));
		put(b_word(13'd8, 5'd3, 5'd1, 3'b000));  // beq not taken
		put(s_word(12'h18c, 5'd3, 5'd0));
		jal_pc = 32'(pc_idx * 4);
		put(jal_word(21'd8, 5'd4));
		put(s_word(12'h190, 5'd3, 5'd0));
		put(s_word(12'h194, 5'd4, 5'd0));
		end_program();
		release_reset();
		run_to_done(name);
		check_word({name, " beq taken marker"}, 0, wcount[8'h60]);
		check_word({name, " bne fall through"}, 7, dmem[8'h61]);
		check_word({name, " bne taken marker"}, 0, wcount[8'h62]);
		check_word({name, " beq fall through"}, 7, dmem[8'h63]);
		check_word({name, " jal marker"}, 0, wcount[8'h64]);
		check_word({name, " jal link"}, jal_pc + 4, dmem[8'h65]);
		finish_test(name, errs);
	endtask

	task automatic zero_reg_test(string name);
		int errs;
		errs = errors;
		start_test();
		put(i_word(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));
		load_const(5'd1, 32'h1234_5678);
		put(r_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
		put(s_word(12'h100, 5'd0, 5'd0));
		end_program();
		release_reset();
		#1;
		check_addr({name, " reset pc"}, `RESET_PC, pc_o);
		check_word({name, " reset read strobe"}, 0, {31'd0, mem_rd_en_o});
		check_word({name, " reset write strobe"}, 0, {31'd0, mem_wr_en_o});
		run_to_done(name);
		check_word({name, " x0 store"}, 0, dmem[8'h40]);
		finish_test(name, errs);
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		int          k0;
		void'($urandom(32'hd662_d05a));
		arst_n_i    = 1'b0;
		stall_if_i  = 1'b0;
		stall_mem_i = 1'b0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		failed      = 0;
		a   = $urandom;
		b   = $urandom;
		imm = 12'($urandom);
		k0  = $urandom % 64;
		for (int i = 0; i < 4; i++) begin
			ld_val[i]  = $urandom;
			ld_addr[i] = 12'h200 + 12'(4 * ((k0 + 7 * i) % 64));  // distinct words
		end
		alu_test("alu", a, b, imm, 1'b0);
		mem_test("load_store", 1'b0);
		branch_test("branch_jal");
		alu_test("alu_if_stall", a, b, imm, 1'b1);
		mem_test("load_store_mem_stall", 1'b1);
		zero_reg_test("x0_reset");
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
core_pkg.sv
pc_gen.sv
if_stage.sv
id_stage.sv
regs.sv
ex_stage.sv
ctrl.sv
core.sv
tb_core.sv

// File: run.sh
#!/bin/bash
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f vlog.f -o tb_core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
